// File: include/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Register file geometry
`define REG_ADDR_W 5
`define NUM_REGS   (1 << `REG_ADDR_W)

`define XLEN 32 // Datapath width

// Data memory is word indexed
`define DMEM_AW    6
`define DMEM_WORDS (1 << `DMEM_AW)

// Where a stage's destination value comes from
`define WRSEL_W          2
`define WRREG_ALURESULT  2'd0
`define WRREG_IMMDATA    2'd1
`define WRREG_MEMDATA    2'd2

`endif

// File: rtl/isa_pkg.sv
`include "core_consts.svh"

package isa_pkg;

	// The four operations the core understands
	typedef enum logic [1:0] {
		OP_ADD   = 2'd0,
		OP_LI    = 2'd1,
		OP_LOAD  = 2'd2,
		OP_STORE = 2'd3
	} op_t;

	// Instruction as it arrives, already decoded
	typedef struct packed {
		op_t                    op;
		logic [`REG_ADDR_W-1:0] ra;
		logic [`REG_ADDR_W-1:0] rb;
		logic [`REG_ADDR_W-1:0] rt; // Destination, or store data source
		logic [`XLEN-1:0]       imm;
	} instr_t;

endpackage

// File: rtl/pipe_pkg.sv
`include "core_consts.svh"

package pipe_pkg;

	// ID holds the instruction unchanged
	typedef isa_pkg::instr_t id_rec_t;

	// Operands in EX are already forwarded
	typedef struct packed {
		isa_pkg::op_t           op;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`XLEN-1:0]       ra_val;
		logic [`XLEN-1:0]       rb_val;
		logic [`XLEN-1:0]       rt_val; // Store data
		logic [`XLEN-1:0]       imm;
	} ex_rec_t;

	// Result leaving MEM, with the load data already merged in
	typedef struct packed {
		logic                   do_reg_write;
		logic [`REG_ADDR_W-1:0] dst_addr;
		logic [`XLEN-1:0]       result;
	} mem_rec_t;

	// WB carries the same fields one cycle later
	typedef mem_rec_t wb_rec_t;

endpackage

// File: rtl/wb_bus_if.sv
`timescale 1ns/1ps
`include "core_consts.svh"

interface wb_bus_if;

	logic                   do_reg_write;
	logic                   do_dm_read;
	logic [`WRSEL_W-1:0]    select_write_reg;
	logic [`REG_ADDR_W-1:0] write_reg_addr;
	logic [`XLEN-1:0]       write_reg_data;
	logic [`XLEN-1:0]       imm_extend;

	modport src (output do_reg_write, do_dm_read, select_write_reg,
		write_reg_addr, write_reg_data, imm_extend);

	// Forwarding and the register file only look
	modport fwd (input do_reg_write, do_dm_read, select_write_reg,
		write_reg_addr, write_reg_data, imm_extend);

endinterface

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`REG_ADDR_W-1:0] ra_addr,
	input  logic [`REG_ADDR_W-1:0] rb_addr,
	input  logic [`REG_ADDR_W-1:0] rt_addr,
	output logic [`XLEN-1:0]       ra_data,
	output logic [`XLEN-1:0]       rb_data,
	output logic [`XLEN-1:0]       rt_data,
	wb_bus_if.fwd                  wb
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb.do_reg_write) begin
			regs[wb.write_reg_addr] <= wb.write_reg_data;
		end
	end

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr]; // Old value here, WB bypass in forward covers it

endmodule

// File: rtl/forward.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module forward (
	input  logic [`REG_ADDR_W-1:0] reg_ra_addr,
	input  logic [`REG_ADDR_W-1:0] reg_rb_addr,
	input  logic [`REG_ADDR_W-1:0] reg_rt_addr,
	input  logic [`XLEN-1:0]       reg_ra_data,
	input  logic [`XLEN-1:0]       reg_rb_data,
	input  logic [`XLEN-1:0]       reg_rt_data,
	wb_bus_if.fwd                  ex,
	wb_bus_if.fwd                  mem,
	wb_bus_if.fwd                  wb,
	output logic [`XLEN-1:0]       f_reg_ra_data,
	output logic [`XLEN-1:0]       f_reg_rb_data,
	output logic [`XLEN-1:0]       f_reg_rt_data,
	output logic                   hazard
);

	logic [`REG_ADDR_W-1:0] src_addr [3];
	logic [`XLEN-1:0]       src_data [3];
	logic [`XLEN-1:0]       fwd_data [3];
	logic                   ex_fwd_en;
	logic [`XLEN-1:0]       ex_fwd_data;

	assign src_addr = '{reg_ra_addr, reg_rb_addr, reg_rt_addr};
	assign src_data = '{reg_ra_data, reg_rb_data, reg_rt_data};

	// A load in EX has no data yet
	assign ex_fwd_en = ex.do_reg_write && !ex.do_dm_read &&
		(ex.select_write_reg == `WRREG_IMMDATA || ex.select_write_reg == `WRREG_ALURESULT);
	assign ex_fwd_data = (ex.select_write_reg == `WRREG_IMMDATA) ? ex.imm_extend
		: ex.write_reg_data;

	// Later assignments win, so the youngest producer takes priority
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			fwd_data[i] = src_data[i];
			if (wb.do_reg_write && src_addr[i] == wb.write_reg_addr)
				fwd_data[i] = wb.write_reg_data;
			if (mem.do_reg_write && src_addr[i] == mem.write_reg_addr)
				fwd_data[i] = mem.write_reg_data;
			if (ex_fwd_en && src_addr[i] == ex.write_reg_addr)
				fwd_data[i] = ex_fwd_data;
		end
	end

	assign f_reg_ra_data = fwd_data[0];
	assign f_reg_rb_data = fwd_data[1];
	assign f_reg_rt_data = fwd_data[2];

	assign hazard = ex.do_dm_read && (reg_ra_addr == ex.write_reg_addr ||
		reg_rb_addr == ex.write_reg_addr || reg_rt_addr == ex.write_reg_addr);

endmodule

// File: rtl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     hold,
	input  logic     bubble,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (bubble)
			out_valid <= 1'b0; // Slot goes empty, payload is don't care
		else if (!hold)
			out_valid <= in_valid;
	end

	// Payload only moves when a real stage advance happens
	always_ff @(posedge clk) begin
		if (!hold && !bubble)
			out_data <= in_data;
	end

endmodule

// File: rtl/exec_mem_unit.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module exec_mem_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              ex_valid,
	input  pipe_pkg::ex_rec_t ex_rec,
	wb_bus_if.src             ex,
	wb_bus_if.src             mem,
	output pipe_pkg::mem_rec_t mem_rec
);

	logic [`XLEN-1:0]       alu_result;
	logic [`XLEN-1:0]       addr_sum;
	logic [`DMEM_AW-1:0]    dm_addr;
	logic                   is_load, is_store, ex_reg_write;
	logic [`WRSEL_W-1:0]    ex_sel;
	logic [`XLEN-1:0]       dmem [`DMEM_WORDS];
	logic [`XLEN-1:0]       dm_rdata;
	logic                   m_reg_write;
	logic [`WRSEL_W-1:0]    m_sel;
	logic [`REG_ADDR_W-1:0] m_addr;
	logic [`XLEN-1:0]       m_alu, m_imm, mem_data;

	assign alu_result   = ex_rec.ra_val + ex_rec.rb_val;
	assign addr_sum     = ex_rec.ra_val + ex_rec.imm;
	assign dm_addr      = addr_sum[`DMEM_AW-1:0]; // Upper address bits wrap
	assign is_load      = ex_valid && ex_rec.op == isa_pkg::OP_LOAD;
	assign is_store     = ex_valid && ex_rec.op == isa_pkg::OP_STORE;
	assign ex_reg_write = ex_valid && ex_rec.op != isa_pkg::OP_STORE;

	always_comb begin
		case (ex_rec.op)
			isa_pkg::OP_LI:   ex_sel = `WRREG_IMMDATA;
			isa_pkg::OP_LOAD: ex_sel = `WRREG_MEMDATA;
			default:          ex_sel = `WRREG_ALURESULT;
		endcase
	end

	assign ex.do_reg_write     = ex_reg_write;
	assign ex.do_dm_read       = is_load;
	assign ex.select_write_reg = ex_sel;
	assign ex.write_reg_addr   = ex_rec.rt;
	assign ex.write_reg_data   = alu_result;
	assign ex.imm_extend       = ex_rec.imm;

	// Store and load both happen at the edge closing EX
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (is_store) begin
			dmem[dm_addr] <= ex_rec.rt_val;
		end
	end

	always_ff @(posedge clk) begin
		if (is_load)
			dm_rdata <= dmem[dm_addr];
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			m_reg_write <= 1'b0;
		else
			m_reg_write <= ex_reg_write;
	end

	always_ff @(posedge clk) begin
		m_sel  <= ex_sel;
		m_addr <= ex_rec.rt;
		m_alu  <= alu_result;
		m_imm  <= ex_rec.imm;
	end

	always_comb begin
		case (m_sel)
			`WRREG_IMMDATA: mem_data = m_imm;
			`WRREG_MEMDATA: mem_data = dm_rdata;
			default:        mem_data = m_alu;
		endcase
	end

	assign mem.do_reg_write     = m_reg_write;
	assign mem.do_dm_read       = m_reg_write && m_sel == `WRREG_MEMDATA;
	assign mem.select_write_reg = m_sel;
	assign mem.write_reg_addr   = m_addr;
	assign mem.write_reg_data   = mem_data;
	assign mem.imm_extend       = m_imm;

	assign mem_rec = '{do_reg_write: m_reg_write, dst_addr: m_addr, result: mem_data};

endmodule

// File: rtl/core_top.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  isa_pkg::op_t           in_op,
	input  logic [`REG_ADDR_W-1:0] in_ra,
	input  logic [`REG_ADDR_W-1:0] in_rb,
	input  logic [`REG_ADDR_W-1:0] in_rt,
	input  logic [`XLEN-1:0]       in_imm,
	output logic                   in_ready,
	output logic                   wb_valid,
	output logic [`REG_ADDR_W-1:0] wb_addr,
	output logic [`XLEN-1:0]       wb_data
);

	pipe_pkg::id_rec_t  in_instr, id_rec;
	pipe_pkg::ex_rec_t  ex_rec_in, ex_rec;
	pipe_pkg::mem_rec_t mem_rec;
	pipe_pkg::wb_rec_t  wb_rec;
	logic               id_valid, ex_valid, hazard;
	logic [`XLEN-1:0]   ra_data, rb_data, rt_data;
	logic [`XLEN-1:0]   f_ra_data, f_rb_data, f_rt_data;

	wb_bus_if ex_bus ();
	wb_bus_if mem_bus ();
	wb_bus_if wb_bus ();

	assign in_instr = '{op: in_op, ra: in_ra, rb: in_rb, rt: in_rt, imm: in_imm};
	assign in_ready = !hazard;

	pipe_reg #(.payload_t(pipe_pkg::id_rec_t)) id_stage (.clk, .rst_n, .hold(hazard),
		.bubble(1'b0), .in_valid, .in_data(in_instr), .out_valid(id_valid), .out_data(id_rec));

	reg_file u_reg_file (.clk, .rst_n, .ra_addr(id_rec.ra), .rb_addr(id_rec.rb),
		.rt_addr(id_rec.rt), .ra_data, .rb_data, .rt_data, .wb(wb_bus));

	forward u_forward (.reg_ra_addr(id_rec.ra), .reg_rb_addr(id_rec.rb),
		.reg_rt_addr(id_rec.rt), .reg_ra_data(ra_data), .reg_rb_data(rb_data),
		.reg_rt_data(rt_data), .ex(ex_bus), .mem(mem_bus), .wb(wb_bus),
		.f_reg_ra_data(f_ra_data), .f_reg_rb_data(f_rb_data), .f_reg_rt_data(f_rt_data),
		.hazard);

	assign ex_rec_in = '{op: id_rec.op, rt: id_rec.rt, ra_val: f_ra_data,
		rb_val: f_rb_data, rt_val: f_rt_data, imm: id_rec.imm};

	pipe_reg #(.payload_t(pipe_pkg::ex_rec_t)) ex_stage (.clk, .rst_n, .hold(1'b0),
		.bubble(hazard), .in_valid(id_valid), .in_data(ex_rec_in),
		.out_valid(ex_valid), .out_data(ex_rec));

	exec_mem_unit u_exec_mem (.clk, .rst_n, .ex_valid, .ex_rec, .ex(ex_bus),
		.mem(mem_bus), .mem_rec);

	// Only register writers travel into WB
	pipe_reg #(.payload_t(pipe_pkg::wb_rec_t)) wb_stage (.clk, .rst_n, .hold(1'b0),
		.bubble(1'b0), .in_valid(mem_bus.do_reg_write), .in_data(mem_rec),
		.out_valid(wb_valid), .out_data(wb_rec));

	assign wb_bus.do_reg_write     = wb_valid && wb_rec.do_reg_write;
	assign wb_bus.do_dm_read       = 1'b0;
	assign wb_bus.select_write_reg = `WRREG_ALURESULT; // Load data merged in MEM
	assign wb_bus.write_reg_addr   = wb_rec.dst_addr;
	assign wb_bus.write_reg_data   = wb_rec.result;
	assign wb_bus.imm_extend       = '0;

	assign wb_addr = wb_rec.dst_addr;
	assign wb_data = wb_rec.result;

endmodule

// File: sim/core_properties.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_properties (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   hazard,
	input logic                   ex_load,
	input logic                   ex_valid,
	input logic [`REG_ADDR_W-1:0] ex_addr,
	input logic [`REG_ADDR_W-1:0] src_ra,
	input logic [`REG_ADDR_W-1:0] src_rb,
	input logic [`REG_ADDR_W-1:0] src_rt
);

	logic load_match;

	assign load_match = ex_load && (src_ra == ex_addr || src_rb == ex_addr || src_rt == ex_addr);

	// One bubble always clears the load out of EX
	a_single_stall: assert property (@(posedge clk) disable iff (!rst_n) hazard |=> !hazard)
		else $error("hazard stayed high for two cycles");

	// Operands picked while a matching load sits in EX never reach EX
	a_no_load_bypass: assert property (@(posedge clk) disable iff (!rst_n)
		load_match |=> !ex_valid)
		else $error("operand taken from a load still in EX entered EX");

	a_id_hold: assert property (@(posedge clk) disable iff (!rst_n)
		hazard |=> $stable({src_ra, src_rb, src_rt}))
		else $error("ID instruction changed during a load-use stall");

endmodule

// File: sim/core_checker.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_checker (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   in_ready,
	input logic                   wb_valid,
	input logic [`REG_ADDR_W-1:0] wb_addr,
	input logic [`XLEN-1:0]       wb_data
);

	logic [`REG_ADDR_W-1:0] exp_addr [$];
	logic [`XLEN-1:0]       exp_data [$];
	string                  test_name = "none";
	int                     errors = 0;
	int                     test_errors = 0;
	int                     tests_run = 0;
	int                     wb_count = 0;
	int                     stall_count = 0;

	function automatic void push_expected(logic [`REG_ADDR_W-1:0] a, logic [`XLEN-1:0] d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endfunction

	function automatic int pending();
		return exp_addr.size();
	endfunction

	function automatic void note_failure(string msg);
		$display("%s: %s", test_name, msg);
		errors++;
		test_errors++;
	endfunction

	function automatic void begin_test(string name);
		test_name = name;
		test_errors = 0;
	endfunction

	function automatic void end_test();
		tests_run++;
		$display("test %s: %s (%0d errors)", test_name, test_errors == 0 ? "ok" : "bad",
			test_errors);
	endfunction

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		logic [`REG_ADDR_W-1:0] a;
		logic [`XLEN-1:0]       d;
		if (rst_n) begin
			if (!in_ready)
				stall_count++;
			if (wb_valid) begin
				wb_count++;
				if (exp_addr.size() == 0) begin
					note_failure("a writeback came out with nothing expected");
				end else begin
					a = exp_addr.pop_front();
					d = exp_data.pop_front();
					if (wb_addr !== a || wb_data !== d) begin
						$display("ERR %s: expected r%0d=%08h, actual r%0d=%08h",
							test_name, a, d, wb_addr, wb_data);
						errors++;
						test_errors++;
					end
				end
			end
		end
	end

endmodule

// File: sim/core_tb.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module core_tb;

	logic clk = 1'b0, rst_n = 1'b0, in_valid = 1'b0, in_ready, wb_valid;
	isa_pkg::op_t in_op = isa_pkg::OP_ADD;
	logic [`REG_ADDR_W-1:0] in_ra = '0, in_rb = '0, in_rt = '0, wb_addr;
	logic [`XLEN-1:0] in_imm = '0, wb_data;
	logic [`XLEN-1:0] ref_regs [`NUM_REGS];
	logic [`XLEN-1:0] ref_mem [`DMEM_WORDS];
	int seed = 32'hbba78785;
	int writers = 0;

	always #50 clk = ~clk;

	core_top dut (.*);
	core_checker chk (.clk, .rst_n, .in_ready, .wb_valid, .wb_addr, .wb_data);

	bind core_top core_properties u_props (.clk, .rst_n, .hazard, .ex_load(ex_bus.do_dm_read),
		.ex_valid(ex_valid), .ex_addr(ex_bus.write_reg_addr), .src_ra(id_rec.ra),
		.src_rb(id_rec.rb), .src_rt(id_rec.rt));

	// Executes one instruction in program order and queues its writeback
	function automatic void exec_ref(isa_pkg::op_t op, logic [4:0] ra, logic [4:0] rb,
		logic [4:0] rt, logic [31:0] imm);
		logic [31:0] sum;
		logic [31:0] res;
		sum = ref_regs[ra] + imm;
		case (op)
			isa_pkg::OP_ADD:  res = ref_regs[ra] + ref_regs[rb];
			isa_pkg::OP_LI:   res = imm;
			isa_pkg::OP_LOAD: res = ref_mem[sum[`DMEM_AW-1:0]];
			default:          res = '0;
		endcase
		if (op == isa_pkg::OP_STORE) begin
			ref_mem[sum[`DMEM_AW-1:0]] = ref_regs[rt];
		end else begin
			ref_regs[rt] = res;
			chk.push_expected(rt, res);
			writers++;
		end
	endfunction

	task automatic give_up(string msg);
		$display("timeout: %s", msg);
		$display("=== FAIL ===");
		$finish;
	endtask

	task automatic issue(isa_pkg::op_t op, logic [4:0] ra, logic [4:0] rb, logic [4:0] rt,
		logic [31:0] imm);
		int waited;
		waited = 0;
		in_valid = 1'b1;
		in_op = op;
		in_ra = ra;
		in_rb = rb;
		in_rt = rt;
		in_imm = imm;
		@(negedge clk);
		while (!in_ready) begin
			waited++;
			if (waited > 20)
				give_up("in_ready stayed low");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0; // Accepted at that edge
		exec_ref(op, ra, rb, rt, imm);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (chk.pending() != 0) begin
			waited++;
			if (waited > 50)
				give_up("expected writebacks never came out");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		int s0;
		int w0;
		int r;
		for (int i = 0; i < `NUM_REGS; i++)
			ref_regs[i] = '0;
		for (int i = 0; i < `DMEM_WORDS; i++)
			ref_mem[i] = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		chk.begin_test("reset");
		@(negedge clk);
		if (!in_ready || wb_valid)
			chk.note_failure("in_ready low or wb_valid high after reset");
		@(posedge clk);
		#1;
		issue(isa_pkg::OP_LOAD, 5'd0, 5'd0, 5'd2, 32'd37);
		drain();
		chk.end_test();

		chk.begin_test("bypass_distance");
		issue(isa_pkg::OP_LI, 5'd0, 5'd0, 5'd1, 32'd3);
		issue(isa_pkg::OP_LI, 5'd0, 5'd0, 5'd2, 32'd4);
		issue(isa_pkg::OP_ADD, 5'd1, 5'd2, 5'd3, 32'd0);
		issue(isa_pkg::OP_ADD, 5'd3, 5'd3, 5'd4, 32'd0);
		issue(isa_pkg::OP_ADD, 5'd3, 5'd4, 5'd5, 32'd0);
		issue(isa_pkg::OP_ADD, 5'd3, 5'd1, 5'd6, 32'd0);
		issue(isa_pkg::OP_ADD, 5'd5, 5'd6, 5'd7, 32'd0);
		drain();
		chk.end_test();

		chk.begin_test("li_use");
		issue(isa_pkg::OP_LI, 5'd0, 5'd0, 5'd9, 32'hdead_beef);
		issue(isa_pkg::OP_ADD, 5'd9, 5'd1, 5'd10, 32'd0);
		drain();
		chk.end_test();

		chk.begin_test("load_use");
		issue(isa_pkg::OP_LI, 5'd0, 5'd0, 5'd11, 32'd5);
		drain();
		s0 = chk.stall_count;
		issue(isa_pkg::OP_LOAD, 5'd11, 5'd0, 5'd12, 32'd2);
		issue(isa_pkg::OP_ADD, 5'd12, 5'd11, 5'd13, 32'd0);
		drain();
		if (chk.stall_count - s0 != 1)
			chk.note_failure("in_ready was not low for exactly one cycle");
		chk.end_test();

		chk.begin_test("store_load");
		issue(isa_pkg::OP_LI, 5'd0, 5'd0, 5'd14, 32'd42);
		issue(isa_pkg::OP_STORE, 5'd11, 5'd0, 5'd14, 32'd4);
		issue(isa_pkg::OP_LOAD, 5'd0, 5'd0, 5'd15, 32'd9);
		issue(isa_pkg::OP_ADD, 5'd15, 5'd15, 5'd16, 32'd0);
		drain();
		chk.end_test();

		chk.begin_test("random");
		w0 = chk.wb_count;
		writers = 0;
		for (int n = 0; n < 200; n++) begin
			r = $random(seed);
			issue(isa_pkg::op_t'(r[1:0]), r[6:2], r[11:7], r[16:12], $random(seed));
		end
		drain();
		if (chk.wb_count - w0 != writers)
			chk.note_failure("writeback count differs from accepted register writers");
		chk.end_test();

		$display("tests %0d, writebacks %0d, errors %0d", chk.tests_run, chk.wb_count,
			chk.errors);
		if (chk.errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		#2000000;
		give_up("simulation ran too long");
	end

endmodule

// File: filelist.f
+incdir+include
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/wb_bus_if.sv
rtl/reg_file.sv
rtl/forward.sv
rtl/pipe_reg.sv
rtl/exec_mem_unit.sv
rtl/core_top.sv
sim/core_properties.sv
sim/core_checker.sv
sim/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb \
	-f filelist.f -o core_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
	exit 0
fi
exit 1
